//--- src/lc_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed 32x32 cell grid, four 16-bit rows per tile
// frame buffer word address is {cell y, tile row, cell x}
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lc_pkg;

	// grid and tile geometry
	localparam int GRID_BITS = 5;
	localparam int MAP_CELLS = 1 << (2 * GRID_BITS);
	localparam int TILE_ROWS = 4;
	localparam int ROW_BITS  = 2;
	localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(TILE_ROWS - 1);

	// frame buffer bus, four 4-bit pixels per word
	localparam int FB_AW = 12;
	localparam int FB_DW = 16;

	// trail codes
	localparam logic [2:0] TRAIL_NONE = 3'd0;
	localparam logic [2:0] B_HORIZ    = 3'd1;
	localparam logic [2:0] B_VERT     = 3'd2;
	localparam logic [2:0] R_HORIZ    = 3'd3;
	localparam logic [2:0] R_VERT     = 3'd4;
	localparam logic [2:0] CORNER     = 3'd5;

	localparam logic [1:0] DIR_UP    = 2'd0;
	localparam logic [1:0] DIR_DOWN  = 2'd1;
	localparam logic [1:0] DIR_LEFT  = 2'd2;
	localparam logic [1:0] DIR_RIGHT = 2'd3;

	// palette indices
	localparam logic [3:0] BLUE_PIX   = 4'h9;
	localparam logic [3:0] RED_PIX    = 4'hC;
	localparam logic [3:0] CORNER_PIX = 4'hF;

	typedef enum logic [1:0] {KIND_HORIZ, KIND_VERT, KIND_CORNER} seg_kind;

	// x and y are the cell that was left behind
	typedef struct packed {
		logic                 moved;
		seg_kind              kind;
		logic [GRID_BITS-1:0] x;
		logic [GRID_BITS-1:0] y;
	} seg_t;

endpackage

//--- src/wb_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic, write only, no byte selects
// req side carries one pulse per write, done answers it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

interface wb_if;
	logic                    cyc;
	logic                    stb;
	logic                    we;
	logic [lc_pkg::FB_AW-1:0] adr;
	logic [lc_pkg::FB_DW-1:0] dat_w;
	logic                    ack;

	// request side toward the controller
	logic                    req;
	logic [lc_pkg::FB_AW-1:0] req_adr;
	logic [lc_pkg::FB_DW-1:0] req_dat;
	logic                    done;

	modport ctrl (output req, req_adr, req_dat, input done);
	modport bus (input req, req_adr, req_dat, ack, output cyc, stb, we, adr, dat_w, done);
endinterface

//--- src/trail_classify.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one player; the last drawn cell only moves on track
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module trail_classify (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  logic                        track,
	input  logic [lc_pkg::GRID_BITS-1:0] head_x,
	input  logic [lc_pkg::GRID_BITS-1:0] head_y,
	input  logic [1:0]                  dir,
	output lc_pkg::seg_t                seg
);

	logic [lc_pkg::GRID_BITS-1:0] last_x;
	logic [lc_pkg::GRID_BITS-1:0] last_y;
	logic [1:0]                   last_dir;

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			last_x   <= '0;
			last_y   <= '0;
			last_dir <= lc_pkg::DIR_UP;
		end
		else if (track)
		begin
			last_x   <= head_x;
			last_y   <= head_y;
			last_dir <= dir;
		end
	end

	always_comb
	begin
		seg.moved = (head_x != last_x) || (head_y != last_y);
		seg.x     = last_x;
		seg.y     = last_y;
		// a turn since the last drawn cell wins over the heading
		if (dir != last_dir)
			seg.kind = lc_pkg::KIND_CORNER;
		else
		begin
			case (dir)
				lc_pkg::DIR_UP, lc_pkg::DIR_DOWN:    seg.kind = lc_pkg::KIND_VERT;
				lc_pkg::DIR_LEFT, lc_pkg::DIR_RIGHT: seg.kind = lc_pkg::KIND_HORIZ;
				default:                             seg.kind = lc_pkg::KIND_HORIZ;
			endcase
		end
	end

endmodule

//--- src/trail_tile_rom.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational; unknown codes give an empty row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module trail_tile_rom (
	input  logic [2:0]                 code,
	input  logic [lc_pkg::ROW_BITS-1:0] row,
	output logic [lc_pkg::FB_DW-1:0]    word
);

	logic [3:0] pix;
	logic       mid_row;

	// rows 1 and 2 carry the horizontal bar
	assign mid_row = (row == 2'd1) || (row == 2'd2);

	always_comb
	begin
		case (code)
			lc_pkg::B_HORIZ, lc_pkg::B_VERT: pix = lc_pkg::BLUE_PIX;
			lc_pkg::R_HORIZ, lc_pkg::R_VERT: pix = lc_pkg::RED_PIX;
			default:                         pix = lc_pkg::CORNER_PIX;
		endcase

		// pixel 0 sits in the top nibble
		case (code)
			lc_pkg::B_HORIZ, lc_pkg::R_HORIZ: word = mid_row ? {4{pix}} : '0;
			lc_pkg::B_VERT, lc_pkg::R_VERT:   word = {4'h0, pix, pix, 4'h0};
			lc_pkg::CORNER:                   word = mid_row ? {4{pix}} : {4'h0, pix, pix, 4'h0};
			default:                          word = '0;
		endcase
	end

endmodule

//--- src/occupancy_map.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one flag per cell, index {y, x}; clear beats marks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module occupancy_map (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  logic                        clear,
	input  logic [lc_pkg::GRID_BITS-1:0] probe_b_x,
	input  logic [lc_pkg::GRID_BITS-1:0] probe_b_y,
	input  logic [lc_pkg::GRID_BITS-1:0] probe_r_x,
	input  logic [lc_pkg::GRID_BITS-1:0] probe_r_y,
	output logic                        hit_b,
	output logic                        hit_r,
	input  logic                        mark_b_en,
	input  logic                        mark_r_en,
	input  logic [lc_pkg::GRID_BITS-1:0] mark_b_x,
	input  logic [lc_pkg::GRID_BITS-1:0] mark_b_y,
	input  logic [lc_pkg::GRID_BITS-1:0] mark_r_x,
	input  logic [lc_pkg::GRID_BITS-1:0] mark_r_y
);

	logic [lc_pkg::MAP_CELLS-1:0] occ;

	// probes see the map before this edge's marks
	assign hit_b = occ[{probe_b_y, probe_b_x}];
	assign hit_r = occ[{probe_r_y, probe_r_x}];

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
			occ <= '0;
		else if (clear)
			occ <= '0;
		else
		begin
			if (mark_b_en)
				occ[{mark_b_y, mark_b_x}] <= 1'b1;
			if (mark_r_en)
				occ[{mark_r_y, mark_r_x}] <= 1'b1;
		end
	end

endmodule

//--- src/fb_wb_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one write at a time and req is ignored while cyc is up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module fb_wb_master (
	input  logic Clk,
	input  logic rst_n,
	wb_if.bus    wb
);

	logic start;

	assign start = wb.req && !wb.cyc;

	// cycle control and done pulse
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb.cyc  <= 1'b0;
			wb.stb  <= 1'b0;
			wb.we   <= 1'b0;
			wb.done <= 1'b0;
		end
		else
		begin
			wb.done <= 1'b0;
			if (wb.cyc && wb.ack)
			begin
				wb.cyc  <= 1'b0;
				wb.stb  <= 1'b0;
				wb.we   <= 1'b0;
				wb.done <= 1'b1;
			end
			else if (start)
			begin
				wb.cyc <= 1'b1;
				wb.stb <= 1'b1;
				wb.we  <= 1'b1;
			end
		end
	end

	// address and data held until ack
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb.adr   <= '0;
			wb.dat_w <= '0;
		end
		else if (start)
		begin
			wb.adr   <= wb.req_adr;
			wb.dat_w <= wb.req_dat;
		end
	end

endmodule

//--- src/trail_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ticks while busy are dropped; busy low in IDLE and DONE
// playing low ends the tile run after the write in flight
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module trail_ctrl (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  logic                        frame_tick,
	input  logic                        playing,
	input  logic [lc_pkg::GRID_BITS-1:0] blue_x,
	input  logic [lc_pkg::GRID_BITS-1:0] blue_y,
	input  logic [lc_pkg::GRID_BITS-1:0] red_x,
	input  logic [lc_pkg::GRID_BITS-1:0] red_y,
	input  lc_pkg::seg_t                seg_b,
	input  lc_pkg::seg_t                seg_r,
	output logic                        track,
	output logic [lc_pkg::GRID_BITS-1:0] probe_b_x,
	output logic [lc_pkg::GRID_BITS-1:0] probe_b_y,
	output logic [lc_pkg::GRID_BITS-1:0] probe_r_x,
	output logic [lc_pkg::GRID_BITS-1:0] probe_r_y,
	input  logic                        hit_b,
	input  logic                        hit_r,
	output logic                        mark_b_en,
	output logic                        mark_r_en,
	output logic [lc_pkg::GRID_BITS-1:0] mark_b_x,
	output logic [lc_pkg::GRID_BITS-1:0] mark_b_y,
	output logic [lc_pkg::GRID_BITS-1:0] mark_r_x,
	output logic [lc_pkg::GRID_BITS-1:0] mark_r_y,
	output logic                        clear,
	output logic [2:0]                  rom_code,
	output logic [lc_pkg::ROW_BITS-1:0]  rom_row,
	input  logic [lc_pkg::FB_DW-1:0]     rom_word,
	wb_if.ctrl                          wb,
	output logic                        busy,
	output logic                        blue_crash,
	output logic                        red_crash
);

	typedef enum logic [2:0] {IDLE, CHECK, WRITE_B, WRITE_R, DONE} state_t;

	state_t                       state;
	lc_pkg::seg_t                 sb_q;
	lc_pkg::seg_t                 sr_q;
	lc_pkg::seg_t                 cur;
	logic [lc_pkg::GRID_BITS-1:0] hb_x;
	logic [lc_pkg::GRID_BITS-1:0] hb_y;
	logic [lc_pkg::GRID_BITS-1:0] hr_x;
	logic [lc_pkg::GRID_BITS-1:0] hr_y;
	logic [lc_pkg::ROW_BITS-1:0]  row_q;
	logic                         pend;
	logic                         writing;
	logic                         accept;
	logic                         heads_meet;

	assign writing = (state == WRITE_B) || (state == WRITE_R);
	assign busy    = (state == CHECK) || writing;
	assign accept  = frame_tick && playing && !busy;
	assign track   = accept || !playing;
	assign clear   = !playing;

	assign probe_b_x  = hb_x;
	assign probe_b_y  = hb_y;
	assign probe_r_x  = hr_x;
	assign probe_r_y  = hr_y;
	assign heads_meet = (hb_x == hr_x) && (hb_y == hr_y);

	// left-behind cells go into the map during CHECK
	assign mark_b_en = (state == CHECK) && sb_q.moved;
	assign mark_r_en = (state == CHECK) && sr_q.moved;
	assign mark_b_x  = sb_q.x;
	assign mark_b_y  = sb_q.y;
	assign mark_r_x  = sr_q.x;
	assign mark_r_y  = sr_q.y;

	assign cur        = (state == WRITE_R) ? sr_q : sb_q;
	assign rom_row    = row_q;
	assign wb.req     = writing && !pend && playing;
	assign wb.req_adr = {cur.y, row_q, cur.x};
	assign wb.req_dat = rom_word;

	always_comb
	begin
		if (!writing)
			rom_code = lc_pkg::TRAIL_NONE;
		else if (cur.kind == lc_pkg::KIND_CORNER)
			rom_code = lc_pkg::CORNER;
		else if (state == WRITE_B)
			rom_code = (cur.kind == lc_pkg::KIND_VERT) ? lc_pkg::B_VERT : lc_pkg::B_HORIZ;
		else
			rom_code = (cur.kind == lc_pkg::KIND_VERT) ? lc_pkg::R_VERT : lc_pkg::R_HORIZ;
	end

	// snapshot of the move at acceptance
	always_ff @(posedge Clk)
	begin
		if (accept)
		begin
			sb_q <= seg_b;
			sr_q <= seg_r;
			hb_x <= blue_x;
			hb_y <= blue_y;
			hr_x <= red_x;
			hr_y <= red_y;
		end
	end

	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			row_q <= '0;
			pend  <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE, DONE:
				begin
					state <= accept ? CHECK : IDLE;
				end
				CHECK:
				begin
					row_q <= '0;
					if (sb_q.moved)
						state <= WRITE_B;
					else if (sr_q.moved)
						state <= WRITE_R;
					else
						state <= DONE;
				end
				WRITE_B, WRITE_R:
				begin
					if (!pend)
					begin
						if (!playing)
							state <= DONE;
						else
							pend <= 1'b1;
					end
					else if (wb.done)
					begin
						pend  <= 1'b0;
						row_q <= row_q + 1'b1;
						if (!playing)
							state <= DONE;
						else if (row_q == lc_pkg::LAST_ROW)
							state <= (state == WRITE_B && sr_q.moved) ? WRITE_R : DONE;
					end
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// sticky until play stops
	always_ff @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else if (!playing)
		begin
			blue_crash <= 1'b0;
			red_crash  <= 1'b0;
		end
		else if (state == CHECK)
		begin
			if (hit_b || heads_meet)
				blue_crash <= 1'b1;
			if (hit_r || heads_meet)
				red_crash <= 1'b1;
		end
	end

endmodule

//--- src/trail_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fb_* is a Wishbone classic master port, writes only
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module trail_top (
	input  logic                        Clk,
	input  logic                        rst_n,
	input  logic                        frame_tick,
	input  logic                        playing,
	input  logic [lc_pkg::GRID_BITS-1:0] blue_x,
	input  logic [lc_pkg::GRID_BITS-1:0] blue_y,
	input  logic [lc_pkg::GRID_BITS-1:0] red_x,
	input  logic [lc_pkg::GRID_BITS-1:0] red_y,
	input  logic [1:0]                  blue_dir,
	input  logic [1:0]                  red_dir,
	output logic                        fb_cyc,
	output logic                        fb_stb,
	output logic                        fb_we,
	output logic [lc_pkg::FB_AW-1:0]     fb_adr,
	output logic [lc_pkg::FB_DW-1:0]     fb_dat_w,
	input  logic                        fb_ack,
	output logic                        busy,
	output logic                        blue_crash,
	output logic                        red_crash
);

	lc_pkg::seg_t                 seg_b;
	lc_pkg::seg_t                 seg_r;
	logic                         track;
	logic                         clear;
	logic [lc_pkg::GRID_BITS-1:0] probe_b_x;
	logic [lc_pkg::GRID_BITS-1:0] probe_b_y;
	logic [lc_pkg::GRID_BITS-1:0] probe_r_x;
	logic [lc_pkg::GRID_BITS-1:0] probe_r_y;
	logic                         hit_b;
	logic                         hit_r;
	logic                         mark_b_en;
	logic                         mark_r_en;
	logic [lc_pkg::GRID_BITS-1:0] mark_b_x;
	logic [lc_pkg::GRID_BITS-1:0] mark_b_y;
	logic [lc_pkg::GRID_BITS-1:0] mark_r_x;
	logic [lc_pkg::GRID_BITS-1:0] mark_r_y;
	logic [2:0]                   rom_code;
	logic [lc_pkg::ROW_BITS-1:0]  rom_row;
	logic [lc_pkg::FB_DW-1:0]     rom_word;

	wb_if wb ();

	assign fb_cyc   = wb.cyc;
	assign fb_stb   = wb.stb;
	assign fb_we    = wb.we;
	assign fb_adr   = wb.adr;
	assign fb_dat_w = wb.dat_w;
	assign wb.ack   = fb_ack;

	trail_classify blue_cls_i (.Clk(Clk), .rst_n(rst_n), .track(track),
		.head_x(blue_x), .head_y(blue_y), .dir(blue_dir), .seg(seg_b));

	trail_classify red_cls_i (.Clk(Clk), .rst_n(rst_n), .track(track),
		.head_x(red_x), .head_y(red_y), .dir(red_dir), .seg(seg_r));

	trail_tile_rom rom_i (.code(rom_code), .row(rom_row), .word(rom_word));

	occupancy_map map_i (.Clk(Clk), .rst_n(rst_n), .clear(clear),
		.probe_b_x(probe_b_x), .probe_b_y(probe_b_y),
		.probe_r_x(probe_r_x), .probe_r_y(probe_r_y),
		.hit_b(hit_b), .hit_r(hit_r),
		.mark_b_en(mark_b_en), .mark_r_en(mark_r_en),
		.mark_b_x(mark_b_x), .mark_b_y(mark_b_y),
		.mark_r_x(mark_r_x), .mark_r_y(mark_r_y));

	fb_wb_master wbm_i (.Clk(Clk), .rst_n(rst_n), .wb(wb.bus));

	trail_ctrl ctrl_i (.Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick),
		.playing(playing), .blue_x(blue_x), .blue_y(blue_y),
		.red_x(red_x), .red_y(red_y), .seg_b(seg_b), .seg_r(seg_r),
		.track(track), .probe_b_x(probe_b_x), .probe_b_y(probe_b_y),
		.probe_r_x(probe_r_x), .probe_r_y(probe_r_y),
		.hit_b(hit_b), .hit_r(hit_r),
		.mark_b_en(mark_b_en), .mark_r_en(mark_r_en),
		.mark_b_x(mark_b_x), .mark_b_y(mark_b_y),
		.mark_r_x(mark_r_x), .mark_r_y(mark_r_y), .clear(clear),
		.rom_code(rom_code), .rom_row(rom_row), .rom_word(rom_word),
		.wb(wb.ctrl), .busy(busy), .blue_crash(blue_crash), .red_crash(red_crash));

endmodule

//--- sim/trail_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound into every fb_wb_master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module trail_chk (
	input logic        Clk,
	input logic        rst_n,
	input logic        req,
	input logic        cyc,
	input logic        stb,
	input logic        ack,
	input logic        done,
	input logic [11:0] adr,
	input logic [15:0] dat_w
);

	int fails = 0;

	// the controller waits for done before the next request
	a_one_req: assert property (@(posedge Clk) disable iff (!rst_n) req |-> !cyc && !done)
		else begin fails++; $error("write request issued while a cycle was open"); end

	// request held steady until ack
	a_hold: assert property (@(posedge Clk) disable iff (!rst_n)
		stb && !ack |=> stb && $stable(adr) && $stable(dat_w))
		else begin fails++; $error("stb, adr or dat_w changed before ack"); end

	a_end: assert property (@(posedge Clk) disable iff (!rst_n) cyc && ack |=> !cyc && done)
		else begin fails++; $error("cycle did not end with done after ack"); end

endmodule

bind fb_wb_master trail_chk chk_i (.Clk(Clk), .rst_n(rst_n), .req(wb.req), .cyc(wb.cyc),
	.stb(wb.stb), .ack(wb.ack), .done(wb.done), .adr(wb.adr), .dat_w(wb.dat_w));

//--- sim/tb_monitor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// samples at the rising edge and assumes idle when playing falls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_monitor (
	input  logic        Clk,
	input  logic        rst_n,
	input  logic        frame_tick,
	input  logic        playing,
	input  logic [4:0]  blue_x,
	input  logic [4:0]  blue_y,
	input  logic [4:0]  red_x,
	input  logic [4:0]  red_y,
	input  logic [1:0]  blue_dir,
	input  logic [1:0]  red_dir,
	input  logic        fb_cyc,
	input  logic        fb_stb,
	input  logic        fb_we,
	input  logic [11:0] fb_adr,
	input  logic [15:0] fb_dat_w,
	input  logic        fb_ack,
	input  logic        busy,
	input  logic        blue_crash,
	input  logic        red_crash,
	output int          errors,
	output int          writes
);

	logic [1023:0] occ;
	logic [4:0]    lb_x;
	logic [4:0]    lb_y;
	logic [4:0]    lr_x;
	logic [4:0]    lr_y;
	logic [1:0]    lb_d;
	logic [1:0]    lr_d;
	logic [11:0]   q_adr[$];
	logic [15:0]   q_dat[$];
	logic          exp_b;
	logic          exp_r;
	logic          new_b;
	logic          new_r;
	logic          check_next;
	logic          busy_q;

	// kind 0 horizontal, 1 vertical, 2 corner
	function automatic logic [1:0] kind_of(input logic [1:0] d, input logic [1:0] last_d);
		if (d != last_d)
			return 2'd2;
		return (d == 2'd0 || d == 2'd1) ? 2'd1 : 2'd0;
	endfunction

	function automatic logic [15:0] tile_word(input logic [3:0] pix, input logic [1:0] kind,
		input logic [1:0] row);
		logic mid;
		logic [3:0] p;
		mid = (row == 2'd1) || (row == 2'd2);
		p = (kind == 2'd2) ? 4'hF : pix;
		if (kind == 2'd0)
			return mid ? {p, p, p, p} : 16'h0;
		if (kind == 2'd2 && mid)
			return {p, p, p, p};
		return {4'h0, p, p, 4'h0};
	endfunction

	task automatic push_tile(input logic [4:0] x, input logic [4:0] y, input logic [1:0] kind,
		input logic [3:0] pix);
		for (int r = 0; r < 4; r++)
		begin
			q_adr.push_back({y, 2'(r), x});
			q_dat.push_back(tile_word(pix, kind, 2'(r)));
		end
	endtask

	always @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			occ = '0;
			{lb_x, lb_y, lr_x, lr_y} = '0;
			lb_d = 2'd0;
			lr_d = 2'd0;
			q_adr.delete();
			q_dat.delete();
			{exp_b, exp_r, new_b, new_r, check_next, busy_q} = '0;
			errors = 0;
			writes = 0;
		end
		else
		begin
			if (blue_crash !== exp_b)
			begin
				$display("ERR %0t blue_crash expected %b got %b", $time, exp_b, blue_crash);
				errors++;
			end
			if (red_crash !== exp_r)
			begin
				$display("ERR %0t red_crash expected %b got %b", $time, exp_r, red_crash);
				errors++;
			end
			if (fb_cyc && fb_stb && fb_ack)
			begin
				writes++;
				if (q_adr.size() == 0)
				begin
					$display("frame-buffer write at %0t was not expected", $time);
					errors++;
				end
				else
				begin
					if (fb_adr !== q_adr[0])
					begin
						$display("ERR %0t fb_adr expected %h got %h", $time, q_adr[0], fb_adr);
						errors++;
					end
					if (fb_we !== 1'b1)
					begin
						$display("ERR %0t fb_we expected 1 got %b", $time, fb_we);
						errors++;
					end
					if (fb_dat_w !== q_dat[0])
					begin
						$display("ERR %0t fb_dat_w expected %h got %h", $time, q_dat[0],
							fb_dat_w);
						errors++;
					end
					void'(q_adr.pop_front());
					void'(q_dat.pop_front());
				end
			end
			if (busy_q && !busy && q_adr.size() != 0)
			begin
				$display("busy fell at %0t with %0d writes missing", $time, q_adr.size());
				errors++;
				q_adr.delete();
				q_dat.delete();
			end
			busy_q = busy;
			if (check_next)
			begin
				exp_b = exp_b | new_b;
				exp_r = exp_r | new_r;
				check_next = 1'b0;
			end
			if (!playing)
			begin
				occ = '0;
				exp_b = 1'b0;
				exp_r = 1'b0;
				lb_x = blue_x;
				lb_y = blue_y;
				lb_d = blue_dir;
				lr_x = red_x;
				lr_y = red_y;
				lr_d = red_dir;
			end
			else if (frame_tick && !busy)
			begin
				// probes see the map before this tick's marks
				new_b = occ[{blue_y, blue_x}] || (blue_x == red_x && blue_y == red_y);
				new_r = occ[{red_y, red_x}] || (blue_x == red_x && blue_y == red_y);
				check_next = 1'b1;
				if (blue_x != lb_x || blue_y != lb_y)
				begin
					push_tile(lb_x, lb_y, kind_of(blue_dir, lb_d), 4'h9);
					occ[{lb_y, lb_x}] = 1'b1;
				end
				if (red_x != lr_x || red_y != lr_y)
				begin
					push_tile(lr_x, lr_y, kind_of(red_dir, lr_d), 4'hC);
					occ[{lr_y, lr_x}] = 1'b1;
				end
				lb_x = blue_x;
				lb_y = blue_y;
				lb_d = blue_dir;
				lr_x = red_x;
				lr_y = red_y;
				lr_d = red_dir;
			end
		end
	end

endmodule

//--- sim/tb_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// playing is only dropped while busy is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_top;

	logic       Clk;
	logic       rst_n;
	logic       frame_tick;
	logic       playing;
	logic [4:0] blue_x;
	logic [4:0] blue_y;
	logic [4:0] red_x;
	logic [4:0] red_y;
	logic [1:0] blue_dir;
	logic [1:0] red_dir;
	logic       fb_cyc;
	logic       fb_stb;
	logic       fb_we;
	logic [11:0] fb_adr;
	logic [15:0] fb_dat_w;
	logic       fb_ack;
	logic       busy;
	logic       blue_crash;
	logic       red_crash;
	logic [15:0] lfsr;
	logic [15:0] ack_lfsr;
	logic [7:0] ack_v;
	int         ack_wait;
	int         errors;
	int         writes;
	logic       timed_out;

	always #50 Clk = ~Clk;

	trail_top dut_i (.Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick), .playing(playing),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir), .fb_cyc(fb_cyc), .fb_stb(fb_stb),
		.fb_we(fb_we), .fb_adr(fb_adr), .fb_dat_w(fb_dat_w), .fb_ack(fb_ack),
		.busy(busy), .blue_crash(blue_crash), .red_crash(red_crash));

	tb_monitor mon_i (.Clk(Clk), .rst_n(rst_n), .frame_tick(frame_tick), .playing(playing),
		.blue_x(blue_x), .blue_y(blue_y), .red_x(red_x), .red_y(red_y),
		.blue_dir(blue_dir), .red_dir(red_dir), .fb_cyc(fb_cyc), .fb_stb(fb_stb),
		.fb_we(fb_we), .fb_adr(fb_adr), .fb_dat_w(fb_dat_w), .fb_ack(fb_ack),
		.busy(busy), .blue_crash(blue_crash), .red_crash(red_crash),
		.errors(errors), .writes(writes));

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(inout logic [15:0] s, input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			s = lfsr_next(s);
			v = {v[6:0], s[0]};
		end
	endtask

	// zero or one cell step in a random direction that wraps at the edge
	task automatic next_cell(input logic [4:0] x, input logic [4:0] y, input logic [1:0] d,
		output logic [4:0] nx, output logic [4:0] ny, output logic [1:0] nd);
		logic [7:0] v;
		nx = x;
		ny = y;
		nd = d;
		take_bits(lfsr, 1, v);
		if (v[0])
		begin
			take_bits(lfsr, 2, v);
			nd = v[1:0];
			case (nd)
				2'd0: ny = y - 5'd1;
				2'd1: ny = y + 5'd1;
				2'd2: nx = x - 5'd1;
				default: nx = x + 5'd1;
			endcase
		end
	endtask

	task automatic move_heads();
		logic [4:0] bx;
		logic [4:0] by;
		logic [4:0] rx;
		logic [4:0] ry;
		logic [1:0] bd;
		logic [1:0] rd;
		next_cell(blue_x, blue_y, blue_dir, bx, by, bd);
		next_cell(red_x, red_y, red_dir, rx, ry, rd);
		blue_x   <= bx;
		blue_y   <= by;
		blue_dir <= bd;
		red_x    <= rx;
		red_y    <= ry;
		red_dir  <= rd;
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < 200 && busy && !timed_out; n++)
			@(posedge Clk);
		if (busy && !timed_out)
		begin
			$display("timeout: busy did not fall within 200 cycles");
			timed_out = 1'b1;
		end
	endtask

	// slave acks after 0 to 3 extra cycles of stb
	always @(posedge Clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fb_ack   <= 1'b0;
			ack_wait = 0;
		end
		else if (fb_ack)
		begin
			fb_ack <= 1'b0;
			take_bits(ack_lfsr, 2, ack_v);
			ack_wait = ack_v[1:0];
		end
		else if (fb_stb)
		begin
			if (ack_wait == 0)
				fb_ack <= 1'b1;
			else
				ack_wait--;
		end
	end

	initial
	begin
		logic [7:0] v;
		int         total;
		lfsr       = 16'd82;
		ack_lfsr   = 16'd82;
		timed_out  = 1'b0;
		Clk        = 1'b0;
		rst_n      = 1'b0;
		frame_tick = 1'b0;
		playing    = 1'b0;
		blue_x     = 5'd5;
		blue_y     = 5'd16;
		red_x      = 5'd26;
		red_y      = 5'd16;
		blue_dir   = 2'd3;
		red_dir    = 2'd2;
		fb_ack     = 1'b0;
		repeat (4) @(posedge Clk);
		rst_n <= 1'b1;
		for (int r = 0; r < 3 && !timed_out; r++)
		begin
			// fresh start cells with blue on the left half and red on the right
			@(posedge Clk);
			take_bits(lfsr, 8, v);
			playing <= 1'b0;
			blue_x  <= {1'b0, v[3:0]};
			red_x   <= {1'b1, v[7:4]};
			take_bits(lfsr, 5, v);
			blue_y  <= v[4:0];
			red_y   <= v[4:0];
			repeat (3) @(posedge Clk);
			playing <= 1'b1;
			for (int t = 0; t < 40; t++)
			begin
				@(posedge Clk);
				wait_idle();
				if (timed_out)
					break;
				move_heads();
				frame_tick <= 1'b1;
				@(posedge Clk);
				take_bits(lfsr, 2, v);
				// extra tick that lands while busy
				if (v[1:0] == 2'd0)
					move_heads();
				else
					frame_tick <= 1'b0;
				@(posedge Clk);
				frame_tick <= 1'b0;
			end
			@(posedge Clk);
			wait_idle();
		end
		playing <= 1'b0;
		frame_tick <= 1'b0;
		repeat (4) @(posedge Clk);
		total = errors + dut_i.wbm_i.chk_i.fails;
		if (timed_out)
			total++;
		if (writes == 0)
		begin
			$display("no frame-buffer writes were seen");
			total++;
		end
		$display("errors %0d, assertion failures %0d, writes %0d", errors,
			dut_i.wbm_i.chk_i.fails, writes);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- build.f
src/lc_pkg.sv
src/wb_if.sv
src/trail_classify.sv
src/trail_tile_rom.sv
src/occupancy_map.sv
src/fb_wb_master.sv
src/trail_ctrl.sv
src/trail_top.sv
sim/trail_chk.sv
sim/tb_monitor.sv
sim/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o sim_tb \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_tb +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
